//--- verilog.f
source/phold_pkg.sv
source/rr_arbiter.sv
source/event_queue.sv
source/lp_core.sv
source/event_scheduler.sv
source/gvt_tracker.sv
source/sim_control.sv
source/phold_top.sv
tests/phold_assertions.sv
tests/phold_tb.sv

//--- tests/phold_tb.sv
`timescale 1ns/1ps
`default_nettype none

module phold_tb;

   import phold_pkg::*;

   localparam int NUM_CORE       = 4;
   localparam int NUM_LP         = 16;
   localparam int PROC_CYCLES    = 4;
   localparam int DELAY_BITS     = 3;
   localparam int SIM_END_TIME   = 100;
   localparam int MODEL_MAX      = NUM_LP + NUM_CORE;
   localparam int TIMEOUT_CYCLES = 20 * SIM_END_TIME * NUM_LP / NUM_CORE;

   logic                clk;
   logic                rst_n;
   logic [time_wid-1:0] gvt;
   logic                done;
   event_trace_t        dispatch_trace;
   event_trace_t        accept_trace;

   lp_event_t           model [MODEL_MAX];   // events waiting in the DUT queue
   int                  model_n;
   lp_event_t           last_disp [NUM_CORE];
   int                  outstanding [NUM_CORE];
   int                  n_dispatch, n_accept, done_cnt, cycle_cnt;
   logic                done_seen, done_prev;
   logic [time_wid-1:0] gvt_prev;

   phold_top #(
      .NUM_CORE(NUM_CORE), .NUM_LP(NUM_LP), .PROC_CYCLES(PROC_CYCLES),
      .DELAY_BITS(DELAY_BITS), .SIM_END_TIME(SIM_END_TIME)
   ) DUT (
      .clk(clk), .rst_n(rst_n), .gvt(gvt), .done(done),
      .dispatch_trace(dispatch_trace), .accept_trace(accept_trace)
   );

   always #4 clk = ~clk;

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         $display("SOME TESTS FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // index of the entry with the smallest {ts, lp} key
   function automatic int min_key_index();
      int best;
      best = 0;
      for (int i = 1; i < model_n; i++) begin
         if (model[i].ts < model[best].ts ||
             (model[i].ts == model[best].ts && model[i].lp < model[best].lp))
            best = i;
      end
      return best;
   endfunction

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      n_dispatch = 0;
      n_accept   = 0;
      done_cnt   = 0;
      cycle_cnt  = 0;
      done_seen  = 1'b0;
      done_prev  = 1'b0;
      gvt_prev   = '0;
      for (int i = 0; i < NUM_LP; i++) begin   // one seed event per lp at t=0
         model[i].lp = lpid_wid'(i);
         model[i].ts = '0;
      end
      model_n = NUM_LP;
      for (int c = 0; c < NUM_CORE; c++) begin
         outstanding[c] = 0;
         last_disp[c]   = '0;
      end
      repeat (3) @(posedge clk);
      #1 rst_n = 1'b1;
      wait (done_cnt > 0);
      repeat (20) @(posedge clk);   // checker keeps running through a quiet period
      if (n_dispatch >= NUM_LP && n_accept > 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         $display("run ended with too few dispatches or no accepted child events");
         $display("SOME TESTS FAILED");
         $fatal(1, "incomplete run");
      end
   end

   always @(posedge clk) begin : watchdog
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout, done never came within %0d cycles", TIMEOUT_CYCLES);
         $display("SOME TESTS FAILED");
         $fatal(1, "simulation timed out");
      end
   end

   // sampled mid-cycle on the falling edge
   always @(negedge clk) begin : compare
      int c;
      int idx;
      int delta;
      if (rst_n) begin
         check("gvt >= previous gvt", gvt >= gvt_prev, 1);
         if (done) begin
            check("done high two cycles", done_prev, 0);
            check("done pulse count", done_cnt, 0);
            check("gvt > SIM_END_TIME at done", gvt > SIM_END_TIME, 1);
            done_cnt++;
         end
         if (done || done_seen) begin
            check("dispatch_trace.valid after done", dispatch_trace.valid, 0);
            check("accept_trace.valid after done", accept_trace.valid, 0);
         end
         if (accept_trace.valid) begin
            c     = int'(accept_trace.core);
            delta = int'(accept_trace.ev.ts) - int'(last_disp[c].ts);
            check("events outstanding on accepting core", outstanding[c], 1);
            check("accept_trace.ev.ts minus parent ts in range",
                  delta >= 1 && delta <= (1 << DELAY_BITS), 1);
            check("accept_trace.ev.lp < NUM_LP", accept_trace.ev.lp < NUM_LP, 1);
            check("model queue has room", model_n < MODEL_MAX, 1);
            model[model_n] = accept_trace.ev;
            model_n++;
            outstanding[c]--;
            n_accept++;
         end
         if (dispatch_trace.valid) begin
            c = int'(dispatch_trace.core);
            check("events outstanding on dispatched core", outstanding[c], 0);
            check("model queue not empty at dispatch", model_n > 0, 1);
            if (n_dispatch < NUM_LP) begin   // seeds leave first in lp order
               check("dispatch_trace.ev.ts of seed", dispatch_trace.ev.ts, 0);
               check("dispatch_trace.ev.lp of seed", dispatch_trace.ev.lp, n_dispatch);
            end
            idx = min_key_index();
            check("dispatch_trace.ev", dispatch_trace.ev, model[idx]);
            check("gvt <= dispatch_trace.ev.ts", gvt <= dispatch_trace.ev.ts, 1);
            model[idx] = model[model_n - 1];
            model_n--;
            last_disp[c] = dispatch_trace.ev;
            outstanding[c]++;
            n_dispatch++;
         end
         gvt_prev  = gvt;
         done_prev = done;
         done_seen = done_seen | done;
      end
   end

endmodule

`default_nettype wire

//--- tests/phold_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module phold_assertions (
   input wire logic                       clk,
   input wire logic                       rst_n,
   input wire logic [phold_pkg::time_wid-1:0] gvt,
   input wire logic                       done,
   input wire phold_pkg::event_trace_t    dispatch_trace,
   input wire phold_pkg::event_trace_t    accept_trace
);

   import phold_pkg::*;

   logic done_seen;   // sticky once the run has ended

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         done_seen <= 1'b0;
      end else if (done) begin
         done_seen <= 1'b1;
      end
   end

   done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else $error("done held high for more than one cycle");

   gvt_no_decrease: assert property (@(posedge clk) disable iff (!rst_n) gvt >= $past(gvt))
      else $error("gvt went backwards");

   // finished state is terminal, nothing moves any more
   no_trace_after_done: assert property (@(posedge clk) disable iff (!rst_n)
      (done || done_seen) |-> (!dispatch_trace.valid && !accept_trace.valid))
      else $error("trace valid after done");

endmodule

bind phold_top phold_assertions u_assertions (
   .clk(clk), .rst_n(rst_n), .gvt(gvt), .done(done),
   .dispatch_trace(dispatch_trace), .accept_trace(accept_trace)
);

`default_nettype wire

//--- source/phold_top.sv
`timescale 1ns/1ps
`default_nettype none

module phold_top #(
   parameter int NUM_CORE     = 4,
   parameter int NUM_LP       = 16,
   parameter int PROC_CYCLES  = 4,
   parameter int DELAY_BITS   = 3,
   parameter int SIM_END_TIME = 100
) (
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   output logic [phold_pkg::time_wid-1:0] gvt,
   output logic                           done,
   output phold_pkg::event_trace_t        dispatch_trace,
   output phold_pkg::event_trace_t        accept_trace
);

   import phold_pkg::*;

   sim_state_t          state;
   logic [lpid_wid-1:0] init_lp;
   logic                q_push, q_pop, q_empty, q_full;
   lp_event_t           q_push_event, q_head, dispatch_event;
   logic [NUM_CORE-1:0] core_ready, child_valid, child_ready, dispatch_valid, core_busy;
   lp_event_t           child_event [NUM_CORE];
   lp_event_t           held_event [NUM_CORE];

   sim_control #(.NUM_LP(NUM_LP), .SIM_END_TIME(SIM_END_TIME)) u_ctrl (
      .clk(clk), .rst_n(rst_n), .gvt(gvt), .state(state), .init_lp(init_lp), .done(done)
   );

   event_scheduler #(.NUM_CORE(NUM_CORE), .NUM_LP(NUM_LP)) u_sched (
      .clk(clk), .rst_n(rst_n), .state(state), .init_lp(init_lp),
      .ready(core_ready), .child_valid(child_valid), .child_event(child_event),
      .child_ready(child_ready), .dispatch_valid(dispatch_valid),
      .dispatch_event(dispatch_event), .push(q_push), .push_event(q_push_event),
      .pop(q_pop), .head(q_head), .empty(q_empty), .full(q_full),
      .dispatch_trace(dispatch_trace), .accept_trace(accept_trace)
   );

   event_queue #(.DEPTH(NUM_LP)) u_queue (   // PHOLD keeps NUM_LP events alive
      .clk(clk), .rst_n(rst_n), .push(q_push), .push_event(q_push_event), .pop(q_pop),
      .head(q_head), .empty(q_empty), .full(q_full), .count()
   );

   gvt_tracker #(.NUM_CORE(NUM_CORE)) u_gvt (
      .clk(clk), .rst_n(rst_n), .state(state), .head(q_head), .empty(q_empty),
      .busy(core_busy), .held_event(held_event), .gvt(gvt)
   );

   for (genvar g = 0; g < NUM_CORE; g++) begin : g_core
      lp_core #(
         .PROC_CYCLES(PROC_CYCLES), .DELAY_BITS(DELAY_BITS), .NUM_LP(NUM_LP),
         .SEED(16'h5eed + 16'(g) * 16'h0b17)   // distinct nonzero seed per core
      ) u_core (
         .clk(clk), .rst_n(rst_n), .dispatch_valid(dispatch_valid[g]),
         .dispatch_event(dispatch_event), .ready(core_ready[g]),
         .child_valid(child_valid[g]), .child_event(child_event[g]),
         .child_ready(child_ready[g]), .busy(core_busy[g]), .held_event(held_event[g])
      );
   end

endmodule

`default_nettype wire

//--- source/sim_control.sv
`timescale 1ns/1ps
`default_nettype none

module sim_control #(
   parameter int NUM_LP       = 16,
   parameter int SIM_END_TIME = 100
) (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire logic [phold_pkg::time_wid-1:0] gvt,
   output phold_pkg::sim_state_t              state,
   output logic [phold_pkg::lpid_wid-1:0]     init_lp,
   output logic                               done
);

   import phold_pkg::*;

   sim_state_t next_state;
   logic       init_last;   // final seed event this cycle

   assign init_last = (init_lp == lpid_wid'(NUM_LP - 1));

   always_comb begin
      next_state = state;
      case (state)
         st_idle:     next_state = st_init;
         st_init:     if (init_last) next_state = st_ready;
         st_ready:    next_state = st_running;
         st_running:  if (gvt > SIM_END_TIME) next_state = st_finished;
         st_finished: next_state = st_finished;   // held until reset
         default:     next_state = st_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= st_idle;
         init_lp <= '0;
         done    <= 1'b0;
      end else begin
         state   <= next_state;
         init_lp <= (state == st_init) ? init_lp + 1'b1 : '0;
         done    <= (state == st_running) && (next_state == st_finished);   // single pulse
      end
   end

endmodule

`default_nettype wire

//--- source/gvt_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module gvt_tracker #(
   parameter int NUM_CORE = 4
) (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   input  wire phold_pkg::sim_state_t    state,
   input  wire phold_pkg::lp_event_t     head,
   input  wire logic                     empty,
   input  wire logic [NUM_CORE-1:0]      busy,
   input  wire phold_pkg::lp_event_t     held_event [NUM_CORE],
   output logic [phold_pkg::time_wid-1:0] gvt
);

   import phold_pkg::*;

   logic [time_wid-1:0] min_ts;
   logic                min_vld;   // at least one live event seen

   // lowest timestamp over queue head and events still in cores
   always_comb begin
      min_vld = !empty;
      min_ts  = head.ts;
      for (int c = 0; c < NUM_CORE; c++) begin
         if (busy[c] && (!min_vld || held_event[c].ts < min_ts)) begin
            min_ts  = held_event[c].ts;
            min_vld = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (state == st_running && min_vld) begin
         gvt <= min_ts;   // otherwise hold last value
      end
   end

endmodule

`default_nettype wire

//--- source/event_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module event_scheduler #(
   parameter int NUM_CORE = 4,
   parameter int NUM_LP   = 16
) (
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire phold_pkg::sim_state_t         state,
   input  wire logic [phold_pkg::lpid_wid-1:0] init_lp,
   // core side
   input  wire logic [NUM_CORE-1:0]           ready,
   input  wire logic [NUM_CORE-1:0]           child_valid,
   input  wire phold_pkg::lp_event_t          child_event [NUM_CORE],
   output logic [NUM_CORE-1:0]                child_ready,
   output logic [NUM_CORE-1:0]                dispatch_valid,
   output phold_pkg::lp_event_t               dispatch_event,
   // queue side
   output logic                               push,
   output phold_pkg::lp_event_t               push_event,
   output logic                               pop,
   input  wire phold_pkg::lp_event_t          head,
   input  wire logic                          empty,
   input  wire logic                          full,
   output phold_pkg::event_trace_t            dispatch_trace,
   output phold_pkg::event_trace_t            accept_trace
);

   import phold_pkg::*;

   logic                  running, in_init;
   logic                  send_valid, recv_valid;
   logic [coreid_wid-1:0] send_idx, recv_idx;
   logic                  accept, dispatch;
   lp_event_t             child_sel;

   rr_arbiter #(.NUM_REQ(NUM_CORE)) send_arb (   // idle cores waiting for work
      .clk(clk), .rst_n(rst_n), .req(ready), .advance(dispatch),
      .grant_valid(send_valid), .grant_idx(send_idx)
   );

   rr_arbiter #(.NUM_REQ(NUM_CORE)) recv_arb (   // cores offering a child
      .clk(clk), .rst_n(rst_n), .req(child_valid), .advance(accept),
      .grant_valid(recv_valid), .grant_idx(recv_idx)
   );

   assign running   = (state == st_running);
   assign in_init   = (state == st_init);
   assign child_sel = child_event[recv_idx];

   // one queue op per cycle, children go first
   assign accept   = running && recv_valid && !full;
   assign dispatch = running && !accept && send_valid && !empty;
   assign push     = in_init || accept;
   assign pop      = dispatch;

   always_comb begin
      if (in_init) begin
         push_event.lp = init_lp & lpid_wid'(NUM_LP - 1);   // seed event per LP at t=0
         push_event.ts = '0;
      end else begin
         push_event = child_sel;
      end
   end

   for (genvar c = 0; c < NUM_CORE; c++) begin : g_core_hs
      assign child_ready[c]    = accept && (recv_idx == coreid_wid'(c));
      assign dispatch_valid[c] = dispatch && (send_idx == coreid_wid'(c));
   end

   assign dispatch_event = head;   // broadcast, only the granted core latches

   assign dispatch_trace = '{valid: dispatch, core: send_idx, ev: head};
   assign accept_trace   = '{valid: accept, core: recv_idx, ev: child_sel};

endmodule

`default_nettype wire

//--- source/lp_core.sv
`timescale 1ns/1ps
`default_nettype none

module lp_core #(
   parameter int          PROC_CYCLES = 4,
   parameter int          DELAY_BITS  = 3,
   parameter int          NUM_LP      = 16,
   parameter logic [15:0] SEED        = 16'h5eed
) (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire logic                  dispatch_valid,
   input  wire phold_pkg::lp_event_t  dispatch_event,
   output logic                       ready,
   output logic                       child_valid,
   output phold_pkg::lp_event_t       child_event,
   input  wire logic                  child_ready,
   output logic                       busy,
   output phold_pkg::lp_event_t       held_event
);

   import phold_pkg::*;

   localparam int         CNT_WID = $clog2(PROC_CYCLES + 1);
   localparam logic [1:0] C_IDLE  = 2'd0;
   localparam logic [1:0] C_PROC  = 2'd1;
   localparam logic [1:0] C_OFFER = 2'd2;

   logic [1:0]            c_state;
   logic [CNT_WID-1:0]    cnt;      // processing cycles left
   logic [15:0]           lfsr;
   logic [DELAY_BITS-1:0] delay;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         c_state <= C_IDLE;
         cnt     <= '0;
         lfsr    <= SEED;
      end else begin
         case (c_state)
            C_IDLE: if (dispatch_valid) begin
               c_state <= C_PROC;
               cnt     <= CNT_WID'(PROC_CYCLES - 1);
               // x^16 + x^14 + x^13 + x^11 + 1, one step per event
               lfsr    <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            end
            C_PROC: if (cnt == '0) c_state <= C_OFFER; else cnt <= cnt - 1'b1;
            C_OFFER: if (child_ready) c_state <= C_IDLE;   // child taken
            default: c_state <= C_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ready && dispatch_valid)
         held_event <= dispatch_event;
   end

   // lfsr is frozen until the next dispatch, so the child stays stable
   assign delay = lfsr[lpid_wid +: DELAY_BITS];

   always_comb begin
      child_event.lp = lfsr[lpid_wid-1:0] & lpid_wid'(NUM_LP - 1);
      child_event.ts = held_event.ts + time_wid'(1) + time_wid'(delay);
   end

   assign ready       = (c_state == C_IDLE);
   assign busy        = !ready;
   assign child_valid = (c_state == C_OFFER);

endmodule

`default_nettype wire

//--- source/event_queue.sv
`timescale 1ns/1ps
`default_nettype none

module event_queue #(
   parameter int DEPTH = 16
) (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire logic                       push,
   input  wire phold_pkg::lp_event_t       push_event,
   input  wire logic                       pop,
   output phold_pkg::lp_event_t            head,
   output logic                            empty,
   output logic                            full,
   output logic [$clog2(DEPTH+1)-1:0]      count
);

   import phold_pkg::*;

   localparam int CNT_WID = $clog2(DEPTH + 1);

   lp_event_t        entry [DEPTH];   // sorted, smallest key in slot 0
   logic [DEPTH-1:0] at_or_after;     // slot is at or above the insert point

   // time first, lp id breaks ties
   function automatic logic [time_wid+lpid_wid-1:0] key_of(input lp_event_t ev);
      return {ev.ts, ev.lp};
   endfunction

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         at_or_after[i] = (i >= int'(count)) ||
                          (key_of(entry[i]) > key_of(push_event));
      end
   end

   always_ff @(posedge clk) begin
      if (push && !full) begin
         if (at_or_after[0])
            entry[0] <= push_event;
         for (int i = 1; i < DEPTH; i++) begin
            if (at_or_after[i - 1])
               entry[i] <= entry[i - 1];   // larger keys move up one slot
            else if (at_or_after[i])
               entry[i] <= push_event;
         end
      end else if (pop && !empty) begin
         for (int i = 0; i < DEPTH - 1; i++)
            entry[i] <= entry[i + 1];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (push && !full) begin
         count <= count + 1'b1;
      end else if (pop && !empty) begin
         count <= count - 1'b1;
      end
   end

   assign head  = entry[0];
   assign empty = (count == '0);
   assign full  = (count == CNT_WID'(DEPTH));

endmodule

`default_nettype wire

//--- source/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
   parameter int NUM_REQ = 4
) (
   input  wire logic                        clk,
   input  wire logic                        rst_n,
   input  wire logic [NUM_REQ-1:0]          req,
   input  wire logic                        advance,
   output logic                             grant_valid,
   output logic [phold_pkg::coreid_wid-1:0] grant_idx
);

   import phold_pkg::*;

   logic [coreid_wid-1:0] ptr;   // requester with top priority

   // walk offsets from far to near so the nearest requester wins
   always_comb begin
      int idx;
      grant_valid = 1'b0;
      grant_idx   = '0;
      for (int i = NUM_REQ - 1; i >= 0; i--) begin
         idx = (int'(ptr) + i) % NUM_REQ;
         if (req[idx]) begin
            grant_valid = 1'b1;
            grant_idx   = coreid_wid'(idx);
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (advance && grant_valid) begin
         if (int'(grant_idx) == NUM_REQ - 1)
            ptr <= '0;
         else
            ptr <= grant_idx + 1'b1;   // winner drops to lowest priority
      end
   end

endmodule

`default_nettype wire

//--- source/phold_pkg.sv
`default_nettype none

package phold_pkg;

   localparam int time_wid   = 16;
   localparam int lpid_wid   = 4;   // caps NUM_LP at 16
   localparam int coreid_wid = 2;   // caps NUM_CORE at 4

   // one simulation event, queue key is {ts, lp}
   typedef struct packed {
      logic [lpid_wid-1:0] lp;
      logic [time_wid-1:0] ts;
   } lp_event_t;

   typedef struct packed {
      logic                  valid;
      logic [coreid_wid-1:0] core;   // core that got or returned the event
      lp_event_t             ev;
   } event_trace_t;

   // run states, finished only left through reset
   typedef enum logic [2:0] {
      st_idle,
      st_init,
      st_ready,
      st_running,
      st_finished
   } sim_state_t;

endpackage

`default_nettype wire
